// ==== verilog/rename_defines.svh ====
/*
 * Rename stage sizing
 * Register counts, tag widths and branch checkpoint depth
 */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural register file
`define LRF_NUM    32
`define LRF_IDX_W  5

// Physical register file
`define PRF_NUM    64
`define PRF_IDX_W  6

`define CKPT_NUM   4   // Max unresolved branches in flight
`define ZERO_AREG  31  // Hardwired zero register, always ready

`endif

// ==== verilog/rename_pkg.sv ====
/*
 * Rename types
 * Architectural index, physical tag, map entry and full map snapshot
 */
`include "rename_defines.svh"

package rename_pkg;

  typedef logic [`LRF_IDX_W-1:0] areg_idx_t;  // Architectural register index
  typedef logic [`PRF_IDX_W-1:0] preg_idx_t;  // Physical register tag

  // One map table entry, ready bit on top
  typedef struct packed {
    logic      rdy;
    preg_idx_t preg;
  } map_entry_t;

  // Whole map table, one entry per areg
  typedef map_entry_t [`LRF_NUM-1:0] map_snap_t;

  // Free-list pointer, MSB is the wrap bit
  typedef logic [`PRF_IDX_W:0] fl_ptr_t;

endpackage

// ==== verilog/branch_pkg.sv ====
/*
 * Branch types
 * Resolution result from the back end and checkpoint FIFO occupancy
 */
`include "rename_defines.svh"

package branch_pkg;

  // Result of the oldest unresolved branch
  typedef enum logic [1:0] {
    NONE    = 2'd0,  // Nothing resolves this cycle
    CORRECT = 2'd1,  // Prediction held, drop checkpoint
    WRONG   = 2'd2   // Mispredict, roll back to checkpoint
  } br_state_e;

  // Needs to hold 0..CKPT_NUM inclusive
  typedef logic [$clog2(`CKPT_NUM):0] ckpt_cnt_t;

endpackage

// ==== verilog/free_list.sv ====
/*
 * Free list
 * Ring of free physical tags with wrap-bit pointers
 * Head pops on rename, tail pushes on retire, head can be restored on mispredict
 */
`timescale 1ns/1ps
`include "rename_defines.svh"

module free_list import rename_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      pop_i,           // Accepted rename takes the head tag
  input  logic      push_i,          // Retire frees a tag
  input  preg_idx_t push_preg_i,
  input  logic      restore_i,       // Mispredict
  input  fl_ptr_t   restore_head_i,  // Head saved at branch dispatch
  output preg_idx_t head_preg_o,
  output fl_ptr_t   head_next_o,     // Head after this cycle's pop
  output logic      not_empty_o
);

  preg_idx_t ring_q [`PRF_NUM];
  fl_ptr_t   head_q;
  fl_ptr_t   tail_q;
  fl_ptr_t   head_inc;

  // Low bits index the ring, top bit tells full from empty
  assign head_inc    = head_q + fl_ptr_t'(1);
  assign head_next_o = pop_i ? head_inc : head_q;
  assign head_preg_o = ring_q[head_q[`PRF_IDX_W-1:0]];
  assign not_empty_o = (head_q != tail_q);

  // Ring contents
  // Slots 0..31 start with tags 32..63, upper slots get filled by retire
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `PRF_NUM; i++) begin
        ring_q[i] <= preg_idx_t'((i + `LRF_NUM) % `PRF_NUM);
      end
    end else if (push_i) begin
      ring_q[tail_q[`PRF_IDX_W-1:0]] <= push_preg_i;
    end
  end

  // Head pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
    end else if (restore_i) begin
      head_q <= restore_head_i;  // Tags popped after the branch come back
    end else if (pop_i) begin
      head_q <= head_inc;
    end
  end

  // Tail pointer, never rolled back
  always_ff @(posedge clk) begin
    if (rst) begin
      tail_q <= fl_ptr_t'(`PRF_NUM - `LRF_NUM);  // 32 free tags after reset
    end else if (push_i) begin
      tail_q <= tail_q + fl_ptr_t'(1);
    end
  end

endmodule

// ==== verilog/map_table.sv ====
/*
 * Rename map table
 * Per areg physical tag and ready bit, read on dispatch, written with new dest tag
 * CDB wakes up matching tags, mispredict reloads the whole table in one cycle
 */
`timescale 1ns/1ps
`include "rename_defines.svh"

module map_table import rename_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Dispatch side
  input  logic      dispatch_en_i,    // Accepted dispatch only
  input  areg_idx_t opa_areg_i,
  input  areg_idx_t opb_areg_i,
  input  areg_idx_t dest_areg_i,
  input  preg_idx_t new_preg_i,       // From free-list head

  // Wakeup
  input  logic      cdb_en_i,
  input  preg_idx_t cdb_preg_i,

  // Recovery
  input  logic      rollback_i,
  input  map_snap_t restore_snap_i,

  output preg_idx_t opa_preg_o,
  output logic      opa_rdy_o,
  output preg_idx_t opb_preg_o,
  output logic      opb_rdy_o,
  output preg_idx_t dest_old_preg_o,  // Freed when this instr retires
  output map_snap_t next_snap_o       // Table state after this cycle, for checkpoints
);

  map_snap_t table_q;
  map_snap_t next_snap;

  // Reads come straight from the stored table
  // No CDB forwarding, a same-cycle wakeup shows up next cycle
  assign opa_preg_o      = dispatch_en_i ? table_q[opa_areg_i].preg : '0;
  assign opb_preg_o      = dispatch_en_i ? table_q[opb_areg_i].preg : '0;
  assign opa_rdy_o       = dispatch_en_i & table_q[opa_areg_i].rdy;
  assign opb_rdy_o       = dispatch_en_i & table_q[opb_areg_i].rdy;
  assign dest_old_preg_o = dispatch_en_i ? table_q[dest_areg_i].preg : '0;

  assign next_snap_o = next_snap;

  // Next table state
  always_comb begin
    next_snap = table_q;  // Hold by default
    if (rollback_i) begin
      next_snap = restore_snap_i;  // Whole table from checkpoint, dispatch and CDB dropped
    end else begin
      // Wakeup every areg currently holding the broadcast tag
      if (cdb_en_i) begin
        for (int i = 0; i < `LRF_NUM; i++) begin
          if (table_q[i].preg == cdb_preg_i) begin
            next_snap[i].rdy = 1'b1;
          end
        end
      end
      // Dest rename goes last so the fresh tag starts not ready
      if (dispatch_en_i) begin
        next_snap[dest_areg_i].preg = new_preg_i;
        next_snap[dest_areg_i].rdy  = 1'b0;
      end
    end
    next_snap[`ZERO_AREG].rdy = 1'b1;  // Zero reg never waits
  end

  // Identity mapping out of reset, all ready
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `LRF_NUM; i++) begin
        table_q[i].preg <= preg_idx_t'(i);
        table_q[i].rdy  <= 1'b1;
      end
    end else begin
      table_q <= next_snap;
    end
  end

endmodule

// ==== verilog/ckpt_store.sv ====
/*
 * Branch checkpoint FIFO
 * One snapshot per unresolved branch, oldest first
 * Pop on correct prediction, flush after a mispredict restore
 */
`timescale 1ns/1ps
`include "rename_defines.svh"

module ckpt_store import branch_pkg::*; #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push_i,       // Branch dispatched
  input  payload_t push_data_i,
  input  logic     pop_i,        // Oldest branch was correct
  input  logic     flush_i,      // Oldest branch was wrong, drop everything
  output payload_t oldest_o,     // Restore value for the oldest branch
  output logic     full_o
);

  localparam int PTR_W = $clog2(`CKPT_NUM);

  payload_t   mem_q [`CKPT_NUM];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  ckpt_cnt_t  cnt_q;
  logic       do_pop;

  assign do_pop   = pop_i & (cnt_q != '0);  // Ignore pop on empty
  assign oldest_o = mem_q[rd_ptr_q];
  assign full_o   = (cnt_q == ckpt_cnt_t'(`CKPT_NUM));

  // Snapshot storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers and occupancy, depth is a power of two so pointers wrap
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_i, do_pop})
        2'b10:   cnt_q <= cnt_q + ckpt_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - ckpt_cnt_t'(1);
        default: cnt_q <= cnt_q;  // Both or neither
      endcase
    end
  end

endmodule

// ==== verilog/rename_unit.sv ====
/*
 * Register rename unit
 * Free list feeds new tags, map table renames, two checkpoint FIFOs back up
 * map and free-list head per branch; stall covers no tags, no checkpoint, recovery
 */
`timescale 1ns/1ps

module rename_unit import rename_pkg::*, branch_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  input  logic      dispatch_en_i,
  input  areg_idx_t opa_areg_i,
  input  areg_idx_t opb_areg_i,
  input  areg_idx_t dest_areg_i,
  input  logic      dispatch_br_i,  // Dispatching instr is a branch

  input  logic      cdb_en_i,
  input  preg_idx_t cdb_preg_i,

  input  logic      retire_en_i,
  input  preg_idx_t retire_preg_i,  // Old dest tag being freed

  input  br_state_e br_state_i,

  output logic      stall_o,
  output preg_idx_t opa_preg_o,
  output logic      opa_rdy_o,
  output preg_idx_t opb_preg_o,
  output logic      opb_rdy_o,
  output preg_idx_t dest_new_preg_o,
  output preg_idx_t dest_old_preg_o
);

  logic      br_correct, br_wrong;
  logic      accept;
  logic      ckpt_push;
  logic      fl_not_empty;
  logic      map_full, ptr_full;
  preg_idx_t fl_head_preg;
  fl_ptr_t   fl_head_next;
  fl_ptr_t   ckpt_head;
  map_snap_t map_next_snap;
  map_snap_t ckpt_snap;

  // Resolve decode
  assign br_correct = (br_state_i == CORRECT);
  assign br_wrong   = (br_state_i == WRONG);

  // No free tag, no room for a branch snapshot, or recovering
  assign stall_o   = ~fl_not_empty | (dispatch_br_i & (map_full | ptr_full)) | br_wrong;
  assign accept    = dispatch_en_i & ~stall_o;
  assign ckpt_push = accept & dispatch_br_i;

  assign dest_new_preg_o = accept ? fl_head_preg : '0;

  free_list free_list_i (
    .clk            (clk),
    .rst            (rst),
    .pop_i          (accept),
    .push_i         (retire_en_i),
    .push_preg_i    (retire_preg_i),
    .restore_i      (br_wrong),
    .restore_head_i (ckpt_head),
    .head_preg_o    (fl_head_preg),
    .head_next_o    (fl_head_next),
    .not_empty_o    (fl_not_empty)
  );

  map_table map_table_i (
    .clk             (clk),
    .rst             (rst),
    .dispatch_en_i   (accept),
    .opa_areg_i      (opa_areg_i),
    .opb_areg_i      (opb_areg_i),
    .dest_areg_i     (dest_areg_i),
    .new_preg_i      (fl_head_preg),
    .cdb_en_i        (cdb_en_i),
    .cdb_preg_i      (cdb_preg_i),
    .rollback_i      (br_wrong),
    .restore_snap_i  (ckpt_snap),
    .opa_preg_o      (opa_preg_o),
    .opa_rdy_o       (opa_rdy_o),
    .opb_preg_o      (opb_preg_o),
    .opb_rdy_o       (opb_rdy_o),
    .dest_old_preg_o (dest_old_preg_o),
    .next_snap_o     (map_next_snap)
  );

  // Map snapshots, includes the branch's own dest write
  ckpt_store #(.payload_t(map_snap_t)) map_ckpt_i (
    .clk         (clk),
    .rst         (rst),
    .push_i      (ckpt_push),
    .push_data_i (map_next_snap),
    .pop_i       (br_correct),
    .flush_i     (br_wrong),
    .oldest_o    (ckpt_snap),
    .full_o      (map_full)
  );

  // Free-list head snapshots, taken after the branch's pop
  ckpt_store #(.payload_t(fl_ptr_t)) ptr_ckpt_i (
    .clk         (clk),
    .rst         (rst),
    .push_i      (ckpt_push),
    .push_data_i (fl_head_next),
    .pop_i       (br_correct),
    .flush_i     (br_wrong),
    .oldest_o    (ckpt_head),
    .full_o      (ptr_full)
  );

endmodule

// ==== dv/clk_gen.sv ====
/*
 * Testbench clock and reset
 * 100 ns clock, active high reset over the first 3 cycles
 */
`timescale 1ns/1ps

module clk_gen #(
  parameter real PERIOD_NS  = 100.0,
  parameter int  RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;  // Drops right after the last reset edge
  end

endmodule

// ==== dv/rename_unit_sva.sv ====
/*
 * Rename rule assertions
 * Bound into the rename unit, free-list and checkpoint occupancy, zero reg and fresh dest tags
 */
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_unit_sva import rename_pkg::*, branch_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      accept_i,
  input logic      retire_en_i,
  input logic      fl_not_empty_i,
  input logic      ckpt_full_i,
  input br_state_e br_state_i,
  input areg_idx_t opa_areg_i,
  input logic      opa_rdy_i,
  input areg_idx_t opb_areg_i,
  input logic      opb_rdy_i,
  input preg_idx_t dest_new_preg_i,
  input preg_idx_t dest_old_preg_i
);

  int fail_cnt = 0;  // Read by the testbench summary

  // Free list refills only through retire or a restored head
  empty_holds: assert property (@(posedge clk) disable iff (rst)
    !fl_not_empty_i && !retire_en_i && br_state_i != WRONG |=> !fl_not_empty_i)
    else begin
      $error("free list gained a tag without retire or restore");
      fail_cnt++;
    end
  retire_refills: assert property (@(posedge clk) disable iff (rst)
    !fl_not_empty_i && retire_en_i |=> fl_not_empty_i)
    else begin
      $error("retired tag did not refill the empty free list");
      fail_cnt++;
    end

  // Snapshots stay until their branch resolves
  full_holds: assert property (@(posedge clk) disable iff (rst)
    ckpt_full_i && br_state_i == NONE |=> ckpt_full_i)
    else begin
      $error("checkpoint store lost an entry with no branch resolving");
      fail_cnt++;
    end

  // Zero reg reads ready even after a rename
  zero_ready: assert property (@(posedge clk) disable iff (rst)
    accept_i |-> (opa_areg_i != `ZERO_AREG || opa_rdy_i) &&
                 (opb_areg_i != `ZERO_AREG || opb_rdy_i))
    else begin
      $error("zero register read as not ready");
      fail_cnt++;
    end

  fresh_tag: assert property (@(posedge clk) disable iff (rst)
    accept_i |-> dest_new_preg_i != dest_old_preg_i)  // New tag must come from the free pool
    else begin
      $error("new dest tag equals the old mapping");
      fail_cnt++;
    end

endmodule

bind rename_unit rename_unit_sva rename_unit_sva_i (
  .clk             (clk),
  .rst             (rst),
  .accept_i        (accept),
  .retire_en_i     (retire_en_i),
  .fl_not_empty_i  (fl_not_empty),
  .ckpt_full_i     (map_full | ptr_full),
  .br_state_i      (br_state_i),
  .opa_areg_i      (opa_areg_i),
  .opa_rdy_i       (opa_rdy_o),
  .opb_areg_i      (opb_areg_i),
  .opb_rdy_i       (opb_rdy_o),
  .dest_new_preg_i (dest_new_preg_o),
  .dest_old_preg_i (dest_old_preg_o)
);

// ==== dv/rename_unit_tb.sv ====
/*
 * Rename unit testbench
 * Mirror of map, free list and checkpoints predicts every dispatch read
 */
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_unit_tb import rename_pkg::*, branch_pkg::*; ();

  logic      clk, rst;
  logic      dispatch_en, dispatch_br, cdb_en, retire_en, stall;
  areg_idx_t opa_areg, opb_areg, dest_areg;
  preg_idx_t cdb_preg, retire_preg, opa_preg, opb_preg, dest_new_preg, dest_old_preg;
  logic      opa_rdy, opb_rdy;
  br_state_e br_state;

  map_snap_t m_map;              // Mirror of the map table
  map_snap_t ck_map[$];          // Mirror checkpoints with the oldest in front
  int        ck_head[$];
  preg_idx_t ring[`PRF_NUM];     // Mirror free list indexed by unwrapped head and tail
  preg_idx_t old_q[$];           // Old tags waiting for retire
  int        head, tail, mismatches, timeouts, sva_fails;

  clk_gen clk_gen_i (.clk_o(clk), .rst_o(rst));

  rename_unit rename_unit_i (
    .clk(clk), .rst(rst),
    .dispatch_en_i(dispatch_en), .opa_areg_i(opa_areg), .opb_areg_i(opb_areg),
    .dest_areg_i(dest_areg), .dispatch_br_i(dispatch_br),
    .cdb_en_i(cdb_en), .cdb_preg_i(cdb_preg),
    .retire_en_i(retire_en), .retire_preg_i(retire_preg), .br_state_i(br_state),
    .stall_o(stall), .opa_preg_o(opa_preg), .opa_rdy_o(opa_rdy),
    .opb_preg_o(opb_preg), .opb_rdy_o(opb_rdy),
    .dest_new_preg_o(dest_new_preg), .dest_old_preg_o(dest_old_preg)
  );

  task automatic check_val(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
      mismatches++;
    end
  endtask

  // Holds the dispatch while stalled, then checks reads against the mirror
  task automatic dispatch(input areg_idx_t a, input areg_idx_t b, input areg_idx_t d,
                          input logic br);
    int n;
    dispatch_en = 1'b1;
    dispatch_br = br;
    opa_areg    = a;
    opb_areg    = b;
    dest_areg   = d;
    #1;
    for (n = 0; stall && n < 20; n++) begin
      @(negedge clk);
      #1;
    end
    if (stall) begin
      $display("Timeout: dispatch to areg %0d still stalled after %0d cycles", d, n);
      timeouts++;
    end else begin
      check_val("opa_preg", m_map[a].preg, opa_preg);
      check_val("opa_rdy", m_map[a].rdy, opa_rdy);
      check_val("opb_preg", m_map[b].preg, opb_preg);
      check_val("opb_rdy", m_map[b].rdy, opb_rdy);
      check_val("dest_new_preg", ring[head % `PRF_NUM], dest_new_preg);
      check_val("dest_old_preg", m_map[d].preg, dest_old_preg);
      old_q.push_back(m_map[d].preg);
      m_map[d].preg = ring[head % `PRF_NUM];
      m_map[d].rdy  = (d == `ZERO_AREG);  // Fresh tag waits unless it is the zero reg
      head++;
      if (br) begin
        ck_map.push_back(m_map);  // Snapshot includes the branch's own write
        ck_head.push_back(head);
      end
    end
    @(negedge clk);
    dispatch_en = 1'b0;
    dispatch_br = 1'b0;
  endtask

  // Dispatch that must be refused, then withdrawn
  task automatic offer_stalled(input logic br);
    dispatch_en = 1'b1;
    dispatch_br = br;
    dest_areg   = areg_idx_t'($urandom % 31);
    #1;
    check_val("stall_o", (tail == head) || (br && ck_map.size() == `CKPT_NUM), stall);
    check_val("dest_new_preg stalled", 0, dest_new_preg);
    @(negedge clk);
    dispatch_en = 1'b0;
    dispatch_br = 1'b0;
  endtask

  task automatic broadcast(input preg_idx_t t);
    int i;
    cdb_en   = 1'b1;
    cdb_preg = t;
    @(negedge clk);
    cdb_en = 1'b0;
    for (i = 0; i < `LRF_NUM; i++) begin
      if (m_map[i].preg == t) m_map[i].rdy = 1'b1;  // Every alias wakes up
    end
  endtask

  task automatic retire_tags(input int cnt);
    repeat (cnt) begin
      retire_en   = 1'b1;
      retire_preg = old_q.pop_front();
      ring[tail % `PRF_NUM] = retire_preg;
      tail++;
      @(negedge clk);
    end
    retire_en = 1'b0;
  endtask

  task automatic resolve(input br_state_e st);
    br_state = st;
    @(negedge clk);
    br_state = NONE;
    if (st == CORRECT) begin
      void'(ck_map.pop_front());
      void'(ck_head.pop_front());
    end else if (st == WRONG) begin
      m_map = ck_map[0];  // Back to just after the oldest branch
      head  = ck_head[0];
      ck_map.delete();
      ck_head.delete();
    end
  endtask

  // Reads every areg once, renaming only the zero reg
  task automatic read_all();
    int k;
    for (k = 0; k < `LRF_NUM / 2; k++) begin
      dispatch(areg_idx_t'(k), areg_idx_t'(`LRF_NUM - 1 - k), areg_idx_t'(`ZERO_AREG), 1'b0);
    end
  endtask

  initial begin
    int n;
    areg_idx_t d;
    void'($urandom(32'hcc07_d1ea));
    dispatch_en = 1'b0;
    dispatch_br = 1'b0;
    opa_areg    = '0;
    opb_areg    = '0;
    dest_areg   = '0;
    cdb_en      = 1'b0;
    cdb_preg    = '0;
    retire_en   = 1'b0;
    retire_preg = '0;
    br_state    = NONE;
    for (n = 0; n < `PRF_NUM - `LRF_NUM; n++) ring[n] = preg_idx_t'(`LRF_NUM + n);  // Tags 32 up
    for (n = 0; n < `LRF_NUM; n++) m_map[n] = '{rdy: 1'b1, preg: preg_idx_t'(n)};
    head = 0;
    tail = `PRF_NUM - `LRF_NUM;
    @(negedge clk);
    for (n = 0; rst && n < 10; n++) @(negedge clk);
    if (rst) begin
      $display("Timeout: reset never released");
      timeouts++;
    end
    #1;
    check_val("stall_o after reset", 0, stall);
    check_val("opa_preg idle", 0, opa_preg);
    @(negedge clk);

    read_all();  // Identity map with every areg ready
    for (n = 0; n < 16; n++) begin
      d = areg_idx_t'($urandom % 31);
      dispatch(areg_idx_t'($urandom), areg_idx_t'($urandom), d, 1'b0);
      if ($urandom % 2) begin
        broadcast(m_map[d].preg);
      end
      repeat ($urandom % 3) @(negedge clk);
    end
    offer_stalled(1'b0);  // No free tag left after 32 renames
    retire_tags(12);

    for (n = 0; n < 4; n++) begin
      dispatch(areg_idx_t'($urandom), areg_idx_t'($urandom), areg_idx_t'($urandom % 31), 1'b1);
      dispatch(areg_idx_t'($urandom), areg_idx_t'($urandom), areg_idx_t'($urandom % 31), 1'b0);
    end
    offer_stalled(1'b1);  // Fifth branch finds the store full
    resolve(CORRECT);
    dispatch(areg_idx_t'($urandom), areg_idx_t'($urandom), areg_idx_t'(`ZERO_AREG), 1'b0);
    resolve(WRONG);
    retire_tags(8);
    read_all();  // Whole table after rollback

    sva_fails = rename_unit_i.rename_unit_sva_i.fail_cnt;
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, sva_fails);
    if (mismatches + timeouts + sva_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/rename_pkg.sv
verilog/branch_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/ckpt_store.sv
verilog/rename_unit.sv
dv/clk_gen.sv
dv/rename_unit_sva.sv
dv/rename_unit_tb.sv
